/* design/fuse_isa_pkg.sv */
`default_nettype none

`include "fuse_params.svh"

package fuse_isa_pkg;

  // Opcodes a producer may send into the front end
  // LDI loads the immediate into rd, the rest are register to register
  typedef enum logic [`FUSE_OPC_W-1:0] {
    NOP    = 4'h0,
    ADD    = 4'h1,
    SUB    = 4'h2,
    LDI    = 4'h3,
    SHL    = 4'h4,
    AND_OP = 4'h5,
    OR_OP  = 4'h6,
    XOR_OP = 4'h7
  } opcode_e;

  // One incoming micro-op, opcode in the top bits
  // For ADD the result is rd = rd + rs
  typedef struct packed {
    opcode_e                 opcode;
    logic [`FUSE_REG_W-1:0]  rd;
    logic [`FUSE_REG_W-1:0]  rs;
    logic [`FUSE_IMM_W-1:0]  imm;
  } micro_op_t;

endpackage

`default_nettype wire

/* design/fuse_mop_pkg.sv */
`default_nettype none

`include "fuse_params.svh"

package fuse_mop_pkg;

  // Opcodes leaving the fuser
  // Plain ops keep their input code so conversion is a straight cast
  typedef enum logic [`FUSE_OPC_W-1:0] {
    MOP_NOP  = 4'h0,
    MOP_ADD  = 4'h1,
    MOP_SUB  = 4'h2,
    MOP_LDI  = 4'h3,
    MOP_SHL  = 4'h4,
    MOP_AND  = 4'h5,
    MOP_OR   = 4'h6,
    MOP_XOR  = 4'h7,
    MOP_ADDI = `FUSE_ADDI_CODE
  } mop_opcode_e;

  // Output op, same field layout as the input micro-op
  typedef struct packed {
    mop_opcode_e             opcode;
    logic [`FUSE_REG_W-1:0]  rd;
    logic [`FUSE_REG_W-1:0]  rs;
    logic [`FUSE_IMM_W-1:0]  imm;
  } macro_op_t;

  // SKIP swallows the ADD that was folded into an ADDI
  typedef enum logic {
    IDLE = 1'b0,
    SKIP = 1'b1
  } fuser_state_e;

endpackage

`default_nettype wire

/* design/fuse_params.svh */
`ifndef FUSE_PARAMS_SVH
`define FUSE_PARAMS_SVH

// Opcode field width of every op
`define FUSE_OPC_W 4

// Register index width, shared by rd and rs
`define FUSE_REG_W 4

// Immediate field width, carried by LDI and the fused ADDI
`define FUSE_IMM_W 4

// Whole op, opcode down to immediate
`define FUSE_OP_W (`FUSE_OPC_W + 2 * `FUSE_REG_W + `FUSE_IMM_W)

// Output code of the fused add immediate, outside the input opcode range
`define FUSE_ADDI_CODE 4'hF

`endif

/* design/fuse_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fuse_params.svh"

// Front end with macro-op fusion
// Ops go through the glass spill register, then through the fuser
module fuse_top
  import fuse_isa_pkg::*;
  import fuse_mop_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [`FUSE_OP_W-1:0] in_op_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [`FUSE_OP_W-1:0] out_op_o,
  input  logic                  flush_i
);

  // Typed views of the flat port vectors
  micro_op_t in_op;
  macro_op_t out_op;

  assign in_op    = in_op_i;
  assign out_op_o = out_op;

  // Buffer to fuser link, including the look-ahead entry
  op_stream_if u_stream ();

  // Flush reaches both stages through the link
  assign u_stream.flush = flush_i;

  glass_spill_register #(
    .T(micro_op_t)
  ) u_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_op),
    .out_o   (u_stream.buffer)
  );

  op_fuser u_fuser (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_i        (u_stream.fuser),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_op_o    (out_op)
  );

endmodule

`default_nettype wire

/* design/glass_spill_register.sv */
`timescale 1ns/1ns
`default_nettype none

// Two-entry spill register that breaks every combinational path between
// its input and output handshakes
// Unlike a plain spill register it also shows the second entry it holds,
// so the consumer can look one op ahead
module glass_spill_register
  import fuse_isa_pkg::*;
#(
  parameter type T = micro_op_t
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        valid_i,
  output logic        ready_o,
  input  T            data_i,
  op_stream_if.buffer out_o
);

  // Register A takes new input
  T     a_data_q;
  logic a_full_q;
  logic a_fill;
  logic a_drain;

  // Register B keeps the op that stalled downstream
  T     b_data_q;
  logic b_full_q;
  logic b_fill;
  logic b_drain;

  // A loads straight from the producer
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  // A new fill wins over a drain in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  // B only ever loads the old contents of A
  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  // Accept from the producer whenever one register is free
  // A flush blocks the fill so nothing is taken on that edge
  assign a_fill = valid_i && ready_o && !out_o.flush;

  // A empties whenever B is free, either into the consumer or into B
  assign a_drain = (a_full_q && !b_full_q) || out_o.flush;

  // A moves over to B when the consumer refuses it
  assign b_fill = a_drain && !out_o.ready && !out_o.flush;

  // B leaves once the consumer takes it
  assign b_drain = (b_full_q && out_o.ready) || out_o.flush;

  // Ready depends on the full flags only, never on the consumer
  assign ready_o = !a_full_q || !b_full_q;

  // Valid comes from registers, so it never follows ready combinationally
  assign out_o.valid = a_full_q || b_full_q;

  // B always holds the older op, so it is the head when full
  assign out_o.data = b_full_q ? b_data_q : a_data_q;

  // With both registers full the younger op in A sits behind the head
  assign out_o.valid_queue = a_full_q && b_full_q;
  assign out_o.data_queue  = b_full_q ? a_data_q : b_data_q;

endmodule

`default_nettype wire

/* design/op_fuser.sv */
`timescale 1ns/1ns
`default_nettype none

// Macro-op fusion stage
// LDI t,k followed by ADD t,t becomes one ADDI t,t,k
// Every other op passes through with its fields untouched
module op_fuser
  import fuse_isa_pkg::*;
  import fuse_mop_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  op_stream_if.fuser in_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output macro_op_t  out_op_o
);

  fuser_state_e state_q;
  fuser_state_e state_d;

  // Current head and the op behind it
  micro_op_t head;
  micro_op_t queued;

  // Fusion decode
  logic head_is_ldi;
  logic queued_is_add;
  logic operands_match;
  logic can_fuse;
  logic wait_for_queue;

  // Handshake toward the output and back to the buffer
  logic offer;
  logic pop;
  logic out_fire;

  // Candidate output ops
  macro_op_t fused_op;
  macro_op_t plain_op;

  assign head   = in_i.data;
  assign queued = in_i.data_queue;

  assign head_is_ldi   = (head.opcode == LDI);
  assign queued_is_add = (queued.opcode == ADD);

  // The ADD has to read and write the register the LDI just loaded
  assign operands_match = (queued.rd == head.rd) && (queued.rs == head.rd);

  assign can_fuse = head_is_ldi && in_i.valid_queue && queued_is_add && operands_match;

  // An LDI alone cannot be judged yet, its partner may still arrive
  assign wait_for_queue = head_is_ldi && !in_i.valid_queue;

  // ADDI takes the target register for both operands and the LDI immediate
  assign fused_op.opcode = MOP_ADDI;
  assign fused_op.rd     = head.rd;
  assign fused_op.rs     = head.rd;
  assign fused_op.imm    = head.imm;

  // Input codes map one to one onto output codes
  assign plain_op.opcode = mop_opcode_e'(head.opcode);
  assign plain_op.rd     = head.rd;
  assign plain_op.rs     = head.rs;
  assign plain_op.imm    = head.imm;

  // Offer only in IDLE with a decidable head
  // Nothing leaves during a flush, so the flushed ops are simply dropped
  assign offer = (state_q == IDLE) && in_i.valid && !wait_for_queue && !in_i.flush;

  assign out_valid_o = offer;
  assign out_op_o    = can_fuse ? fused_op : plain_op;
  assign out_fire    = offer && out_ready_i;

  // In IDLE the head leaves together with its output
  // In SKIP the absorbed ADD is popped with no output at all
  always_comb begin
    pop = 1'b0;
    unique case (state_q)
      IDLE: pop = out_fire;
      SKIP: pop = 1'b1;
      default: pop = 1'b0;
    endcase
  end

  assign in_i.ready = pop;

  // Only the LDI is popped with the ADDI, the ADD is still in the buffer
  // and becomes the head one cycle later
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (out_fire && can_fuse) begin
          state_d = SKIP;
        end
      end
      SKIP: begin
        // The absorbed ADD sits at the head and leaves in this cycle
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    // Flush abandons a pending skip along with the buffer contents
    if (in_i.flush) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* design/op_stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Link from the spill buffer to the fuser
// Besides the head op it carries the op queued behind it
interface op_stream_if
  import fuse_isa_pkg::*;
();

  // Head entry handshake
  logic      valid;
  logic      ready;
  micro_op_t data;

  // Second entry, only meaningful while valid_queue is high
  logic      valid_queue;
  micro_op_t data_queue;

  // Empties the buffer and resets the fuser state
  logic      flush;

  // The buffer side produces both entries
  modport buffer (
    output valid, data, valid_queue, data_queue,
    input  ready, flush
  );

  // The fuser consumes both entries and pops the head
  modport fuser (
    input  valid, data, valid_queue, data_queue, flush,
    output ready
  );

endinterface

`default_nettype wire

/* fuse_stream.f */
+incdir+design
design/fuse_isa_pkg.sv
design/fuse_mop_pkg.sv
design/op_stream_if.sv
design/glass_spill_register.sv
design/op_fuser.sv
design/fuse_top.sv
verification/fuse_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fuse_stream testbench with Verilator and runs it
# Exits with status 0 only when the simulation output reports a pass

cd "$(dirname "$0")" || { echo "Cannot enter the project directory"; exit 1; }

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ns -f fuse_stream.f \
  --top-module fuse_tb -Mdir obj_dir -o fuse_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output="$(./obj_dir/fuse_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_output"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verification/fuse_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fuse_params.svh"

// Random testbench for the fusion front end
// A queue of accepted ops serves as the reference model and predicts every output
module fuse_tb
  import fuse_isa_pkg::*;
();

  localparam int PASS_OPS    = 40;
  localparam int FUSE_PAIRS  = 12;
  localparam int NEAR_ROUNDS = 6;
  localparam int BP_OPS      = 80;
  localparam int FLUSH_OPS   = 80;
  // Five phases, each closed by two NOPs
  localparam int TOTAL_OPS = PASS_OPS + 3 * FUSE_PAIRS + 6 * NEAR_ROUNDS + BP_OPS + FLUSH_OPS + 10;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 40 + 500;
  localparam int DRAIN_CYCLES    = 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [`FUSE_OP_W-1:0] in_op_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic [`FUSE_OP_W-1:0] out_op_o;
  logic                  flush_i;

  logic [31:0]           lcg_state;
  logic                  ready_random;
  logic                  in_fire;
  logic                  flush_seen;
  int                    mismatch_count;
  int                    other_count;
  int                    output_count;
  int                    fusion_count;
  logic [`FUSE_OP_W-1:0] model_q[$];

  fuse_top u_fuse_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_op_i     (in_op_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_op_o    (out_op_o),
    .flush_i     (flush_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Numerical Recipes constants, the low byte is dropped since it cycles fast
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, lcg_state[31:8]};
  endfunction

  // Field order is opcode, rd, rs, imm from the top bit down
  function automatic logic [`FUSE_OP_W-1:0] make_op(input logic [`FUSE_OPC_W-1:0] opc,
                                                   input logic [`FUSE_REG_W-1:0] rd,
                                                   input logic [`FUSE_REG_W-1:0] rs,
                                                   input logic [`FUSE_IMM_W-1:0] imm);
    return {opc, rd, rs, imm};
  endfunction

  function automatic logic [`FUSE_OP_W-1:0] random_op(input logic allow_ldi);
    logic [31:0] r;
    logic [3:0]  opc;
    r   = rand32();
    opc = {1'b0, r[2:0]};
    if (!allow_ldi && opc == LDI) begin
      opc = NOP;
    end
    return make_op(opc, r[7:4], r[11:8], r[15:12]);
  endfunction

  // One rising edge, with a fresh out_ready_i when back-pressure is on
  task automatic next_cycle();
    @(posedge clk_i);
    if (ready_random) begin
      out_ready_i <= (rand32() % 32'd100) < 32'd55;
    end else begin
      out_ready_i <= 1'b1;
    end
  endtask

  // Holds the op on the port until it is taken; returns on the accepting edge
  task automatic send_op(input logic [`FUSE_OP_W-1:0] op);
    in_valid_i <= 1'b1;
    in_op_i    <= op;
    next_cycle();
    while (!in_fire) begin
      next_cycle();
    end
  endtask

  task automatic pause_input(input int cycles);
    in_valid_i <= 1'b0;
    repeat (cycles) next_cycle();
  endtask

  // A load and an add that qualify for fusion
  task automatic send_fusable_pair(input logic [31:0] r);
    send_op(make_op(LDI, r[3:0], r[11:8], r[7:4]));
    send_op(make_op(ADD, r[3:0], r[3:0], r[15:12]));
  endtask

  task automatic pulse_flush();
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    next_cycle();
    flush_i    <= 1'b0;
  endtask

  // Trailing NOPs resolve a waiting LDI, then the DUT empties at full speed
  task automatic drain_phase();
    int waited;
    waited = 0;
    send_op('0);
    send_op('0);
    in_valid_i   <= 1'b0;
    ready_random = 1'b0;
    while (model_q.size() != 0 && waited < DRAIN_CYCLES) begin
      next_cycle();
      waited++;
    end
    if (model_q.size() != 0) begin
      other_count++;
      $display("Drain stalled: %0d expected ops never left the DUT", model_q.size());
    end
    // A few more edges let a skipped ADD leave and expose any stray output
    repeat (3) next_cycle();
  endtask

  // Applies the fusion rule to the front of the model queue
  task automatic check_output(input logic [`FUSE_OP_W-1:0] got);
    logic [`FUSE_OP_W-1:0] head;
    logic [`FUSE_OP_W-1:0] next;
    logic [`FUSE_OP_W-1:0] expected;
    logic                  fused;
    output_count++;
    if (model_q.size() == 0) begin
      other_count++;
      $display("Unexpected output %h while the model holds no op", got);
    end else begin
      head  = model_q.pop_front();
      fused = 1'b0;
      if (model_q.size() != 0) begin
        next  = model_q[0];
        fused = (head[15:12] == LDI) && (next[15:12] == ADD) &&
                (next[11:8] == head[11:8]) && (next[7:4] == head[11:8]);
      end
      if (fused) begin
        expected = {`FUSE_ADDI_CODE, head[11:8], head[11:8], head[3:0]};
        void'(model_q.pop_front());
        fusion_count++;
      end else begin
        expected = head;
      end
      if (got !== expected) begin
        mismatch_count++;
        $display("MISMATCH out_op_o: got %h, expected %h", got, expected);
      end
    end
  endtask

  // Sampled on the falling edge, where every input and output has settled
  // Each sample describes the transfers of the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (flush_seen && out_valid_o !== 1'b0) begin
        mismatch_count++;
        $display("MISMATCH out_valid_o after flush: got %h, expected 0", out_valid_o);
      end
      if (out_valid_o && out_ready_i) begin
        check_output(out_op_o);
      end
      in_fire = in_valid_i && in_ready_o;
      if (in_fire) begin
        model_q.push_back(in_op_i);
      end
      if (flush_i) begin
        model_q.delete();
      end
      flush_seen = flush_i;
    end else begin
      in_fire    = 1'b0;
      flush_seen = 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [3:0]  other;
    logic [3:0]  opc;
    int          sent;
    rst_ni         = 1'b0;
    in_valid_i     = 1'b0;
    in_op_i        = '0;
    out_ready_i    = 1'b0;
    flush_i        = 1'b0;
    lcg_state      = 32'h84b;
    ready_random   = 1'b0;
    in_fire        = 1'b0;
    flush_seen     = 1'b0;
    mismatch_count = 0;
    other_count    = 0;
    output_count   = 0;
    fusion_count   = 0;

    repeat (8) @(posedge clk_i);
    rst_ni      <= 1'b1;
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    if (in_ready_o !== 1'b1) begin
      mismatch_count++;
      $display("MISMATCH in_ready_o after reset: got %h, expected 1", in_ready_o);
    end
    if (out_valid_o !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH out_valid_o after reset: got %h, expected 0", out_valid_o);
    end
    @(posedge clk_i);

    // Plain ops at full rate
    for (int i = 0; i < PASS_OPS; i++) begin
      send_op(random_op(1'b0));
    end
    drain_phase();

    // Fusable pairs, each followed by a plain filler op
    for (int i = 0; i < FUSE_PAIRS; i++) begin
      send_fusable_pair(rand32());
      send_op(random_op(1'b0));
    end
    drain_phase();

    // Near misses on rs, on rd and on the opcode
    for (int i = 0; i < NEAR_ROUNDS; i++) begin
      r     = rand32();
      other = r[3:0] + 4'd1;
      opc   = {1'b0, r[10:8]};
      if (opc == ADD) begin
        opc = SUB;
      end
      send_op(make_op(LDI, r[3:0], r[15:12], r[7:4]));
      send_op(make_op(ADD, r[3:0], other, r[7:4]));
      send_op(make_op(LDI, r[3:0], r[15:12], r[7:4]));
      send_op(make_op(ADD, other, r[3:0], r[7:4]));
      send_op(make_op(LDI, r[3:0], r[15:12], r[7:4]));
      send_op(make_op(opc, r[3:0], r[3:0], r[7:4]));
    end
    drain_phase();

    // Random gaps on both sides, with fusable pairs mixed in
    ready_random = 1'b1;
    sent = 0;
    while (sent < BP_OPS) begin
      r = rand32();
      if (r[1:0] == 2'd0) begin
        pause_input(1 + int'(r[2]));
      end
      if (r[4:3] == 2'd0) begin
        send_fusable_pair(rand32());
        sent += 2;
      end else begin
        send_op(random_op(1'b1));
        sent++;
      end
    end
    drain_phase();

    // Same traffic with flush pulses at random points
    ready_random = 1'b1;
    sent = 0;
    while (sent < FLUSH_OPS) begin
      r = rand32();
      if (r[7:5] == 3'd0) begin
        pulse_flush();
      end
      if (r[4:3] == 2'd0) begin
        send_fusable_pair(rand32());
        sent += 2;
      end else begin
        send_op(random_op(1'b1));
        sent++;
      end
    end
    drain_phase();

    $display("Summary: %0d outputs, %0d fusions, %0d mismatches, %0d other errors",
             output_count, fusion_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
